/* logic/dac_ctrl_pkg.sv */
package dac_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and SPI timing

  localparam int NUM_CHANNELS    = 8;
  localparam int PAIRS_PER_WRITE = 4;          // Two channels per pair word
  localparam int SPI_FRAME_BITS  = 24;
  localparam int SPI_CLK_HZ      = 20_000_000;
  localparam int T_UPDATE_NS     = 830;        // n_cs rise to rise, AD5676

  // Update time in SPI clocks, rounded up
  localparam int T_UPDATE_CYCLES =
    (T_UPDATE_NS * (SPI_CLK_HZ / 1_000_000) + 999) / 1000;

  // High time that fills the update time, kept within 4 to 31
  localparam int N_CS_HIGH_CYCLES =
    (T_UPDATE_CYCLES - SPI_FRAME_BITS < 4)  ? 4 :
    (T_UPDATE_CYCLES - SPI_FRAME_BITS > 31) ? 31 :
    T_UPDATE_CYCLES - SPI_FRAME_BITS;

  localparam int ABS_CAL_MAX    = 4096;        // Calibration bound, both signs
  localparam int DAC_MAX_SIGNED = 32767;       // Also the offset of code zero

  localparam logic [3:0]  SPI_CMD_REG_WRITE  = 4'b0001; // Write, load on LDAC
  localparam logic [15:0] DAC_CODE_FORBIDDEN = 16'hFFFF;

  ////////////////////////////////////////////////////////////
  // Types

  typedef logic        [31:0] cmd_word_t;
  typedef logic        [15:0] dac_code_t;    // Offset code, 32767 is zero
  typedef logic signed [15:0] dac_signed_t;
  typedef logic signed [16:0] dac_wide_t;    // Value plus calibration
  typedef logic        [14:0] dac_abs_t;
  typedef logic        [2:0]  chan_t;
  typedef logic        [25:0] delay_t;
  typedef logic [NUM_CHANNELS*15-1:0] abs_concat_t; // Channel 0 in low bits

  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,
    CMD_DAC_WR  = 2'b01,
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11  // Ends a wait, no LDAC
  } cmd_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_DAC_WR,
    S_ERROR
  } seq_state_t;

  // No-op and DAC write layout
  typedef struct packed {
    cmd_op_t op;
    logic    trig;   // Wait for trigger instead of delay
    logic    cont;   // Another word must follow
    logic    ldac;   // Pulse LDAC when done
    logic    spare;
    delay_t  delay;
  } cmd_fields_t;

  // Set-calibration layout
  typedef struct packed {
    cmd_op_t     op;
    logic [10:0] spare;
    chan_t       channel;
    dac_signed_t value;
  } cal_fields_t;

  typedef struct packed {
    dac_code_t hi;   // Odd channel
    dac_code_t lo;   // Even channel
  } dac_pair_t;

  typedef struct packed {
    logic [3:0] cmd;
    logic       rsvd;
    chan_t      chan;
    dac_code_t  value;
  } spi_frame_t;

  typedef struct packed {
    spi_frame_t first;  // Shifted out first
    spi_frame_t second;
  } spi_pair_t;

  typedef struct packed {
    logic underflow;
    logic unexp_trig;
    logic cal_oob;
    logic val_oob;
  } fault_t;

endpackage

/* logic/dac_cmd_seq.sv */
`timescale 1ns/10ps

module dac_cmd_seq (
  input  logic                    clk,
  input  logic                    resetn,
  input  dac_ctrl_pkg::cmd_word_t cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  input  logic                    trigger,
  input  logic                    ldac_shared,
  input  logic                    cal_oob,
  input  logic                    dac_val_oob,
  input  logic                    frame_done,
  input  logic                    pair_ready,
  output logic                    cal_wr,
  output logic                    pair_fetch,
  output dac_ctrl_pkg::chan_t     pair_base,
  output logic                    frame_start,
  output logic                    halt,
  output logic                    waiting_for_trig,
  output logic                    ldac,
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig
);
  import dac_ctrl_pkg::*;

  seq_state_t  state;
  seq_state_t  next_cmd_state;
  cmd_fields_t cmd;            // Current word as a no-op or write
  logic        is_wait_op;
  logic        cmd_done;
  logic        next_cmd;
  logic        cancel_wait;
  logic        do_ldac;
  logic        wait_trig;
  logic        expect_next;
  delay_t      delay_cnt;
  chan_t       chan;
  logic        last_chan;
  logic        fetch_req;      // Current word should be a pair
  logic        wr_done;
  fault_t      fault_now;

  assign cmd        = cmd_word;
  assign is_wait_op = (cmd.op == CMD_NO_OP) || (cmd.op == CMD_DAC_WR);
  assign last_chan  = (chan == chan_t'(2 * PAIRS_PER_WRITE - 1));

  ////////////////////////////////////////////////////////////
  // Command completion

  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT ||
                        (state == S_DAC_WR && wr_done))
                       && !cmd_buf_empty && cmd.op == CMD_CANCEL;

  assign cmd_done = (state == S_IDLE && !cmd_buf_empty)
                    || (state == S_DELAY && delay_cnt == '0)
                    || (state == S_TRIG_WAIT && trigger)
                    || (state == S_DAC_WR && wr_done && !wait_trig && delay_cnt == '0);

  assign next_cmd = cmd_done && !cmd_buf_empty;

  always_comb begin
    if (cmd_buf_empty) begin
      next_cmd_state = S_IDLE;                  // Underflow handled as a fault
    end else begin
      case (cmd.op)
        CMD_NO_OP:  next_cmd_state = cmd.trig ? S_TRIG_WAIT : S_DELAY;
        CMD_DAC_WR: next_cmd_state = S_DAC_WR;
        default:    next_cmd_state = S_IDLE;    // Set-cal and cancel finish at once
      endcase
    end
  end

  // Faults seen this cycle
  always_comb begin
    fault_now.underflow  = ((cmd_done && expect_next) || fetch_req) && cmd_buf_empty;
    fault_now.unexp_trig = (trigger && state != S_TRIG_WAIT)
                           || (ldac_shared && state == S_DAC_WR); // Shared LDAC mid-write
    fault_now.cal_oob    = cal_oob;
    fault_now.val_oob    = dac_val_oob;
  end

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_IDLE;
    else if (|fault_now) state <= S_ERROR;      // Held until reset
    else if (cancel_wait) state <= S_IDLE;
    else if (cmd_done) state <= next_cmd_state;
    else if (state == S_DAC_WR && wr_done) state <= wait_trig ? S_TRIG_WAIT : S_DELAY;
  end

  ////////////////////////////////////////////////////////////
  // Command bits and delay timer

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (next_cmd) begin
      do_ldac     <= is_wait_op && cmd.ldac;    // Cleared by set-cal and cancel
      wait_trig   <= is_wait_op && cmd.trig;
      expect_next <= is_wait_op && cmd.cont;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halt) delay_cnt <= '0;
    else if (next_cmd && is_wait_op && !cmd.trig) delay_cnt <= cmd.delay;
    else if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1; // Runs during a write too
  end

  ////////////////////////////////////////////////////////////
  // Channel sequencing

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      chan      <= '0;
      fetch_req <= 1'b0;
      wr_done   <= 1'b0;
    end else begin
      if (next_cmd && cmd.op == CMD_DAC_WR) chan <= '0;
      else if (state == S_DAC_WR && frame_done) chan <= chan + 1'b1;
      // First pair at once, later pairs after each odd frame
      fetch_req <= (next_cmd && cmd.op == CMD_DAC_WR)
                   || (state == S_DAC_WR && frame_done && chan[0] && !last_chan);
      wr_done   <= state == S_DAC_WR && frame_done && last_chan;
    end
  end

  assign pair_fetch  = fetch_req && !cmd_buf_empty;
  assign pair_base   = {chan[2:1], 1'b0};
  // Even frame once its pair is loaded, odd frame right after the even one
  assign frame_start = state == S_DAC_WR && (pair_ready || (frame_done && !chan[0]));
  assign cal_wr      = next_cmd && cmd.op == CMD_SET_CAL;

  assign cmd_word_rd_en = !halt && !cmd_buf_empty && (fetch_req || cmd_done || cancel_wait);

  ////////////////////////////////////////////////////////////
  // LDAC and sticky flags

  always_ff @(posedge clk) begin
    if (!resetn || halt) ldac <= 1'b0;
    else ldac <= do_ldac && cmd_done && !cancel_wait && state != S_IDLE && !(|fault_now);
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
    end else begin
      if (fault_now.underflow) cmd_buf_underflow <= 1'b1;
      if (fault_now.unexp_trig) unexp_trig <= 1'b1;
    end
  end

  assign halt             = (state == S_ERROR);
  assign waiting_for_trig = (state == S_TRIG_WAIT);

endmodule

/* logic/dac_cal_path.sv */
`timescale 1ns/10ps

module dac_cal_path (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      halt,
  input  logic                      cal_wr,
  input  dac_ctrl_pkg::cal_fields_t cal_cmd,
  input  logic                      pair_fetch,
  input  dac_ctrl_pkg::dac_pair_t   pair_word,
  input  dac_ctrl_pkg::chan_t       pair_base,
  output logic                      pair_ready,
  output dac_ctrl_pkg::spi_pair_t   frames,
  output dac_ctrl_pkg::dac_abs_t    abs_lo,
  output dac_ctrl_pkg::dac_abs_t    abs_hi,
  output logic                      cal_oob,
  output logic                      dac_val_oob
);
  import dac_ctrl_pkg::*;

  dac_signed_t cal_tbl [NUM_CHANNELS];
  logic        cal_in_range;
  logic        code_forbidden;
  logic        s1_valid;
  chan_t       s1_base;
  dac_signed_t s1_lo;
  dac_signed_t s1_hi;
  dac_wide_t   sum_lo;
  dac_wide_t   sum_hi;
  logic        sum_oob;

  function automatic logic wide_oob(dac_wide_t v);
    return (v > DAC_MAX_SIGNED) || (v < -DAC_MAX_SIGNED);
  endfunction

  function automatic dac_abs_t to_abs(dac_wide_t v);
    dac_wide_t mag;
    mag = (v < 0) ? -v : v;
    return mag[14:0];              // Fits once bounds are checked
  endfunction

  // Back to offset code inside a register write frame
  function automatic spi_frame_t make_frame(chan_t ch, dac_wide_t v);
    spi_frame_t f;
    dac_wide_t  code;
    code    = v + dac_wide_t'(DAC_MAX_SIGNED);
    f.cmd   = SPI_CMD_REG_WRITE;
    f.rsvd  = 1'b0;
    f.chan  = ch;
    f.value = code[15:0];
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Calibration table

  assign cal_in_range = (cal_cmd.value <= ABS_CAL_MAX) && (cal_cmd.value >= -ABS_CAL_MAX);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CHANNELS; i++) cal_tbl[i] <= '0;
    end else if (cal_wr && cal_in_range) begin
      cal_tbl[cal_cmd.channel] <= cal_cmd.value;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pair loader

  assign code_forbidden = (pair_word.lo == DAC_CODE_FORBIDDEN)
                          || (pair_word.hi == DAC_CODE_FORBIDDEN);

  // Stage 2 sums, sign extended to 17 bits
  assign sum_lo  = s1_lo + cal_tbl[s1_base];
  assign sum_hi  = s1_hi + cal_tbl[{s1_base[2:1], 1'b1}];
  assign sum_oob = wide_oob(sum_lo) || wide_oob(sum_hi);

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      s1_valid   <= 1'b0;
      pair_ready <= 1'b0;
    end else begin
      s1_valid   <= pair_fetch && !code_forbidden;
      pair_ready <= s1_valid && !sum_oob;   // Two cycles after the fetch
    end
  end

  always_ff @(posedge clk) begin
    if (pair_fetch) begin
      s1_base <= {pair_base[2:1], 1'b0};
      s1_lo   <= dac_signed_t'(pair_word.lo - dac_code_t'(DAC_MAX_SIGNED)); // Offset to signed
      s1_hi   <= dac_signed_t'(pair_word.hi - dac_code_t'(DAC_MAX_SIGNED));
    end
    if (s1_valid) begin
      frames.first  <= make_frame(s1_base, sum_lo);          // Even channel goes first
      frames.second <= make_frame({s1_base[2:1], 1'b1}, sum_hi);
      abs_lo        <= to_abs(sum_lo);
      abs_hi        <= to_abs(sum_hi);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cal_oob     <= 1'b0;
      dac_val_oob <= 1'b0;
    end else begin
      if (cal_wr && !cal_in_range) cal_oob <= 1'b1;
      if ((pair_fetch && code_forbidden) || (s1_valid && sum_oob)) dac_val_oob <= 1'b1;
    end
  end

endmodule

/* logic/dac_spi_tx.sv */
`timescale 1ns/10ps

module dac_spi_tx (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    halt,
  input  logic                    frame_start,
  input  logic                    pair_load,
  input  dac_ctrl_pkg::spi_pair_t frames,
  output logic                    frame_done,
  output logic                    n_cs,
  output logic                    mosi
);
  import dac_ctrl_pkg::*;

  logic [4:0] cs_timer;   // Remaining n_cs high cycles
  logic [4:0] bit_cnt;    // Remaining bits after the current one
  logic       cs_expire;
  spi_pair_t  shreg;

  assign cs_expire = (cs_timer == 5'd1);
  assign mosi      = shreg[$bits(spi_pair_t)-1];   // MSB first

  ////////////////////////////////////////////////////////////
  // Chip select timing

  always_ff @(posedge clk) begin
    if (!resetn || halt) cs_timer <= '0;
    else if (frame_start) cs_timer <= 5'(N_CS_HIGH_CYCLES);
    else if (cs_timer != '0) cs_timer <= cs_timer - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs       <= 1'b1;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (cs_expire) begin
        n_cs    <= 1'b0;                            // Frame begins
        bit_cnt <= 5'(SPI_FRAME_BITS - 1);
      end else if (!n_cs) begin
        if (bit_cnt == '0) begin
          n_cs       <= 1'b1;                       // Rises with frame_done
          frame_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // MOSI shift register

  // Shift after every low cycle, the last one brings the second frame's MSB to the top
  always_ff @(posedge clk) begin
    if (!resetn) shreg <= '0;
    else if (pair_load) shreg <= frames;
    else if (!n_cs) shreg <= {shreg[$bits(spi_pair_t)-2:0], 1'b0};
  end

endmodule

/* logic/shim_dac_ctrl.sv */
`timescale 1ns/10ps

module shim_dac_ctrl (
  input  logic                      clk,
  input  logic                      resetn,
  input  dac_ctrl_pkg::cmd_word_t   cmd_word,
  input  logic                      cmd_buf_empty,
  output logic                      cmd_word_rd_en,
  input  logic                      trigger,
  input  logic                      ldac_shared,
  output logic                      waiting_for_trig,
  output logic                      cmd_buf_underflow,
  output logic                      unexp_trig,
  output logic                      cal_oob,
  output logic                      dac_val_oob,
  output dac_ctrl_pkg::abs_concat_t abs_dac_val_concat,
  output logic                      n_cs,
  output logic                      mosi,
  output logic                      ldac
);
  import dac_ctrl_pkg::*;

  logic      cal_wr;
  logic      pair_fetch;
  chan_t     pair_base;
  logic      pair_ready;
  spi_pair_t frames;
  dac_abs_t  abs_lo;
  dac_abs_t  abs_hi;
  logic      frame_start;
  logic      frame_done;
  logic      halt;
  dac_abs_t  abs_val [NUM_CHANNELS];   // Latest magnitude per channel

  dac_cmd_seq i_dac_cmd_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .trigger           (trigger),
    .ldac_shared       (ldac_shared),
    .cal_oob           (cal_oob),
    .dac_val_oob       (dac_val_oob),
    .frame_done        (frame_done),
    .pair_ready        (pair_ready),
    .cal_wr            (cal_wr),
    .pair_fetch        (pair_fetch),
    .pair_base         (pair_base),
    .frame_start       (frame_start),
    .halt              (halt),
    .waiting_for_trig  (waiting_for_trig),
    .ldac              (ldac),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig)
  );

  // Same buffer word seen as a calibration command or a value pair
  dac_cal_path i_dac_cal_path (
    .clk         (clk),
    .resetn      (resetn),
    .halt        (halt),
    .cal_wr      (cal_wr),
    .cal_cmd     (cal_fields_t'(cmd_word)),
    .pair_fetch  (pair_fetch),
    .pair_word   (dac_pair_t'(cmd_word)),
    .pair_base   (pair_base),
    .pair_ready  (pair_ready),
    .frames      (frames),
    .abs_lo      (abs_lo),
    .abs_hi      (abs_hi),
    .cal_oob     (cal_oob),
    .dac_val_oob (dac_val_oob)
  );

  dac_spi_tx i_dac_spi_tx (
    .clk         (clk),
    .resetn      (resetn),
    .halt        (halt),
    .frame_start (frame_start),
    .pair_load   (pair_ready),
    .frames      (frames),
    .frame_done  (frame_done),
    .n_cs        (n_cs),
    .mosi        (mosi)
  );

  ////////////////////////////////////////////////////////////
  // Absolute values, published with LDAC

  // pair_base holds until the pair's first frame ends
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CHANNELS; i++) abs_val[i] <= '0;
      abs_dac_val_concat <= '0;
    end else begin
      if (pair_ready) begin
        abs_val[pair_base]                <= abs_lo;
        abs_val[{pair_base[2:1], 1'b1}]   <= abs_hi;
      end
      if (ldac) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
          abs_dac_val_concat[i*$bits(dac_abs_t) +: $bits(dac_abs_t)] <= abs_val[i];
        end
      end
    end
  end

endmodule

/* sim/dac_spi_model.sv */
`timescale 1ns/10ps

module dac_spi_model (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    n_cs,
  input  logic                    mosi,
  input  logic                    clear,       // Restarts the frame count
  output logic                    frame_err,
  output int                      n_frames,
  output dac_ctrl_pkg::dac_code_t dac_reg [dac_ctrl_pkg::NUM_CHANNELS],
  output dac_ctrl_pkg::chan_t     wr_order [16]
);
  import dac_ctrl_pkg::*;

  logic [SPI_FRAME_BITS-1:0] sr;   // Bits of the frame so far
  int                        bit_cnt;
  int                        high_cnt;   // n_cs high samples since last frame

  initial begin
    frame_err = 1'b0;
    n_frames  = 0;
    bit_cnt   = 0;
    high_cnt  = N_CS_HIGH_CYCLES;
    sr        = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) dac_reg[i] = '0;
    for (int i = 0; i < 16; i++) wr_order[i] = '0;
  end

  // Decode one register write once n_cs is back high
  task automatic close_frame();
    spi_frame_t f;
    f = sr;
    if (bit_cnt != SPI_FRAME_BITS) begin
      $display("SPI frame had %0d bits instead of %0d", bit_cnt, SPI_FRAME_BITS);
      frame_err = 1'b1;
    end else if (f.cmd != SPI_CMD_REG_WRITE || f.rsvd != 1'b0) begin
      $display("[FAIL] spi frame cmd/rsvd 0x%0h, expected 0x%0h", {f.cmd, f.rsvd},
               {SPI_CMD_REG_WRITE, 1'b0});
      frame_err = 1'b1;
    end else begin
      dac_reg[f.chan] = f.value;                   // Input register of that channel
      if (n_frames < 16) wr_order[n_frames] = f.chan;
      n_frames++;
    end
  endtask

  always @(posedge clk) begin
    if (clear) n_frames = 0;
    if (!resetn) begin
      bit_cnt  = 0;                                // Nothing in flight during reset
      high_cnt = N_CS_HIGH_CYCLES;
    end else if (n_cs == 1'b0) begin
      if (bit_cnt == 0 && high_cnt < N_CS_HIGH_CYCLES) begin
        $display("n_cs was high for only %0d cycles before a frame", high_cnt);
        frame_err = 1'b1;
      end
      sr       = {sr[SPI_FRAME_BITS-2:0], mosi};   // MSB arrives first
      bit_cnt++;
      high_cnt = 0;
    end else begin
      if (bit_cnt != 0) close_frame();
      bit_cnt = 0;
      high_cnt++;
    end
  end

endmodule

/* sim/tb_shim_dac_ctrl.sv */
`timescale 1ns/10ps

module tb_shim_dac_ctrl;
  import dac_ctrl_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 2;          // Input skew after the rising edge, ns
  localparam int WRITE_DELAY  = 400;
  localparam int TRIG_HOLD    = 25;
  localparam int HALT_WATCH   = 300;
  localparam int WRITE_CYCLES =
    32 + NUM_CHANNELS * (SPI_FRAME_BITS + N_CS_HIGH_CYCLES + 1) + WRITE_DELAY;
  localparam int TEST_CYCLES  =
    4 * RESET_CYCLES + WRITE_CYCLES + 2 * (TRIG_HOLD + 40) + HALT_WATCH + 3 * 40;
  localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  logic        clk = 1'b0;
  logic        resetn;
  cmd_word_t   cmd_word;
  logic        cmd_buf_empty;
  logic        cmd_word_rd_en;
  logic        trigger;
  logic        ldac_shared;
  logic        waiting_for_trig;
  logic        cmd_buf_underflow;
  logic        unexp_trig;
  logic        cal_oob;
  logic        dac_val_oob;
  abs_concat_t abs_dac_val_concat;
  logic        n_cs;
  logic        mosi;
  logic        ldac;

  cmd_word_t   buf_q [$];                  // Command buffer contents, head first
  logic        pop_now;
  fault_t      flags;
  logic        legal_phase = 1'b0;         // No fault allowed
  logic        halted_phase = 1'b0;        // Outputs must stay idle
  logic        model_clear;
  logic        model_err;
  int          model_frames;
  dac_code_t   model_reg [NUM_CHANNELS];
  chan_t       model_order [16];
  int          ldac_cnt = 0;
  int          cycle_cnt = 0;

  shim_dac_ctrl i_shim_dac_ctrl (
    .clk                (clk),
    .resetn             (resetn),
    .cmd_word           (cmd_word),
    .cmd_buf_empty      (cmd_buf_empty),
    .cmd_word_rd_en     (cmd_word_rd_en),
    .trigger            (trigger),
    .ldac_shared        (ldac_shared),
    .waiting_for_trig   (waiting_for_trig),
    .cmd_buf_underflow  (cmd_buf_underflow),
    .unexp_trig         (unexp_trig),
    .cal_oob            (cal_oob),
    .dac_val_oob        (dac_val_oob),
    .abs_dac_val_concat (abs_dac_val_concat),
    .n_cs               (n_cs),
    .mosi               (mosi),
    .ldac               (ldac)
  );

  dac_spi_model i_dac_spi_model (
    .clk       (clk),
    .resetn    (resetn),
    .n_cs      (n_cs),
    .mosi      (mosi),
    .clear     (model_clear),
    .frame_err (model_err),
    .n_frames  (model_frames),
    .dac_reg   (model_reg),
    .wr_order  (model_order)
  );

  assign flags = {cmd_buf_underflow, unexp_trig, cal_oob, dac_val_oob};

  always #50 clk = ~clk;                   // 100 ns period

  ////////////////////////////////////////////////////////////
  // Failure reporting

  task automatic end_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_problem(string msg);
    $display("%s", msg);
    end_with_failure();
  endtask

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    assert (got == exp)
      else begin
        $display("[FAIL] %s got 0x%0h, expected 0x%0h", name, got, exp);
        end_with_failure();
      end
  endtask

  assert property (@(posedge clk) !(legal_phase && (|flags)))
    else report_problem("A fault flag rose during a legal command sequence");
  assert property (@(posedge clk) !(halted_phase && (!n_cs || ldac)))
    else report_problem("SPI or LDAC activity after the controller stopped on a fault");
  assert property (@(posedge clk) !model_err)
    else report_problem("The DAC model saw a malformed SPI transfer");

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) report_problem("Timeout, the tests did not finish");
  end

  always @(negedge clk) if (ldac) ldac_cnt++;   // LDAC pulses seen so far

  ////////////////////////////////////////////////////////////
  // Command buffer model, first word falls through

  task automatic refresh_buffer();
    cmd_buf_empty = (buf_q.size() == 0);
    if (cmd_buf_empty) cmd_word = '0;
    else cmd_word = buf_q[0];
  endtask

  task automatic push_word(cmd_word_t w);
    buf_q.push_back(w);
    refresh_buffer();
  endtask

  always begin
    @(negedge clk);
    pop_now = cmd_word_rd_en && !cmd_buf_empty;  // Read taken at the coming edge
    @(posedge clk);
    #DRIVE_DLY;
    if (pop_now) void'(buf_q.pop_front());
    refresh_buffer();
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic step_to_drive();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic cmd_word_t wait_cmd(cmd_op_t op, logic trig, logic cont, logic ld,
                                         int delay);
    cmd_fields_t c;
    c.op    = op;
    c.trig  = trig;
    c.cont  = cont;
    c.ldac  = ld;
    c.spare = 1'b0;
    c.delay = delay_t'(delay);
    return c;
  endfunction

  function automatic cmd_word_t cal_cmd(int ch, dac_signed_t value);
    cal_fields_t c;
    c.op      = CMD_SET_CAL;
    c.spare   = '0;
    c.channel = chan_t'(ch);
    c.value   = value;
    return c;
  endfunction

  // Also checks the idle outputs after each reset
  task automatic apply_reset();
    step_to_drive();
    buf_q.delete();
    refresh_buffer();
    trigger = 1'b0;
    resetn  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    resetn = 1'b1;
    @(negedge clk);
    check_value("n_cs", n_cs, 1);
    check_value("ldac", ldac, 0);
    check_value("cmd_word_rd_en", cmd_word_rd_en, 0);
    check_value("waiting_for_trig", waiting_for_trig, 0);
    check_value("fault flags", flags, 0);
    check_value("abs_dac_val_concat", abs_dac_val_concat, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  // Eight calibrated channels, then LDAC after the delay
  task automatic run_dac_write();
    dac_code_t   code [NUM_CHANNELS];
    dac_signed_t cal [NUM_CHANNELS];
    dac_pair_t   pr;
    int          sv;
    step_to_drive();
    model_clear = 1'b1;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      code[i] = dac_code_t'(8192 + $urandom % 49152);      // Sum stays in range
      cal[i]  = dac_signed_t'(int'($urandom % (2 * ABS_CAL_MAX + 1)) - ABS_CAL_MAX);
      push_word(cal_cmd(i, cal[i]));
    end
    push_word(wait_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b1, WRITE_DELAY));
    for (int p = 0; p < PAIRS_PER_WRITE; p++) begin
      pr.lo = code[2*p];
      pr.hi = code[2*p+1];
      push_word(pr);
    end
    step_to_drive();
    model_clear = 1'b0;
    while (!ldac) @(negedge clk);
    @(negedge clk);                                          // Published after LDAC
    check_value("frames written", model_frames, NUM_CHANNELS);
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      sv = int'(code[i]) - DAC_MAX_SIGNED + int'(cal[i]);
      check_value($sformatf("frame %0d channel", i), model_order[i], i);
      check_value($sformatf("dac_reg[%0d]", i), model_reg[i],
                  dac_code_t'(int'(code[i]) + int'(cal[i])));
      check_value($sformatf("abs_dac_val_concat[ch%0d]", i),
                  abs_dac_val_concat[i*$bits(dac_abs_t) +: $bits(dac_abs_t)],
                  (sv < 0) ? -sv : sv);
    end
    repeat (20) @(negedge clk);
    step_to_drive();
    check_value("ldac pulse count", ldac_cnt, 1);
  endtask

  // Trigger ends one wait with LDAC, cancel ends the next without
  task automatic run_trigger_waits();
    step_to_drive();
    push_word(wait_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    while (!waiting_for_trig) @(negedge clk);
    repeat (TRIG_HOLD) begin
      @(negedge clk);
      check_value("waiting_for_trig", waiting_for_trig, 1);
    end
    step_to_drive();
    trigger = 1'b1;
    step_to_drive();
    trigger = 1'b0;
    @(negedge clk);
    check_value("waiting_for_trig", waiting_for_trig, 0);
    check_value("ldac", ldac, 1);
    step_to_drive();
    check_value("ldac pulse count", ldac_cnt, 2);
    push_word(wait_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 0));
    while (!waiting_for_trig) @(negedge clk);
    repeat (5) @(negedge clk);
    step_to_drive();
    push_word(wait_cmd(CMD_CANCEL, 1'b0, 1'b0, 1'b0, 0));
    while (waiting_for_trig) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_value("ldac", ldac, 0);
    end
    step_to_drive();
    check_value("ldac pulse count", ldac_cnt, 2);
  endtask

  // Out-of-range calibration stops everything, queued words stay put
  task automatic run_cal_fault();
    dac_pair_t pr;
    step_to_drive();
    push_word(cal_cmd(3, dac_signed_t'(ABS_CAL_MAX + 1)));
    while (!cal_oob) @(negedge clk);
    check_value("fault flags", flags, 4'b0010);
    step_to_drive();
    halted_phase = 1'b1;
    push_word(wait_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b1, 0));
    pr = {16'h4000, 16'h9000};
    for (int p = 0; p < PAIRS_PER_WRITE; p++) push_word(pr);
    push_word(wait_cmd(CMD_NO_OP, 1'b0, 1'b0, 1'b1, 5));
    repeat (HALT_WATCH) @(negedge clk);
    step_to_drive();
    halted_phase = 1'b0;
    check_value("words left in buffer", buf_q.size(), PAIRS_PER_WRITE + 2);
  endtask

  initial begin
    resetn      = 1'b0;
    trigger     = 1'b0;
    ldac_shared = 1'b0;
    model_clear = 1'b0;
    refresh_buffer();
    void'($urandom(47565));
    apply_reset();
    legal_phase = 1'b1;
    run_dac_write();
    run_trigger_waits();
    legal_phase = 1'b0;
    run_cal_fault();
    apply_reset();
    step_to_drive();                                  // Trigger while idle
    trigger = 1'b1;
    step_to_drive();
    trigger = 1'b0;
    while (!unexp_trig) @(negedge clk);
    check_value("fault flags", flags, 4'b0100);
    apply_reset();
    step_to_drive();                                  // Forbidden code in a pair
    push_word(wait_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b0, 0));
    push_word({16'h1234, DAC_CODE_FORBIDDEN});
    while (!dac_val_oob) @(negedge clk);
    check_value("fault flags", flags, 4'b0001);
    apply_reset();
    step_to_drive();                                  // Continue bit, nothing behind
    push_word(wait_cmd(CMD_NO_OP, 1'b0, 1'b1, 1'b0, 20));
    while (!cmd_buf_underflow) @(negedge clk);
    check_value("fault flags", flags, 4'b1000);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* build.f */
logic/dac_ctrl_pkg.sv
logic/dac_cmd_seq.sv
logic/dac_cal_path.sv
logic/dac_spi_tx.sv
logic/shim_dac_ctrl.sv
sim/dac_spi_model.sv
sim/tb_shim_dac_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_shim_dac_ctrl \
  -f build.f -Mdir obj_dir -o tb_shim_dac_ctrl > sim.log 2>&1 \
  || { cat sim.log; echo "Build failed"; exit 1; }
./obj_dir/tb_shim_dac_ctrl >> sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
